// ==== Bender.yml ====
package:
  name: cp_dist

sources:
  - rtl/cp_dist_pkg.sv
  - rtl/cp_dist_cell.sv
  - rtl/cp_dist_chain.sv
  - rtl/cp_dist_timer.sv
  - rtl/cp_dist_ctrl_fsm.sv
  - rtl/cp_dist_top.sv
  - target: test
    files:
      - test/tb_cp_dist_top.sv

// ==== compile.f ====
rtl/cp_dist_pkg.sv
rtl/cp_dist_cell.sv
rtl/cp_dist_chain.sv
rtl/cp_dist_timer.sv
rtl/cp_dist_ctrl_fsm.sv
rtl/cp_dist_top.sv
test/tb_cp_dist_top.sv

// ==== rtl/cp_dist_cell.sv ====
/*
 * control-plane distribution cell
 * taps the word for its channel and forwards it down the chain,
 * master or distributed role, bypass and double width pipelines
 */
`timescale 1ns/100ps

module cp_dist_cell
   import cp_dist_pkg::*;
#(
   parameter bit IS_MASTER = 1'b0   // set on the chain head only
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     clr,           // sync flush from the FSM
   input  logic     data_enable,   // advance pipeline
   input  cp_word_t master_in,
   input  cp_word_t dist_in,       // from upstream cell
   input  cp_mode_t mode,
   output cp_word_t dist_out,      // to downstream cell
   output cp_word_t dist_tap       // this channel
);

   cp_word_t stg1_q;   // first stage, captures dist_in
   cp_word_t stg2_q;   // second stage, feeds the next hop
   cp_word_t shd1_q;   // shadow of stg1 for double mode
   cp_word_t shd2_q;   // shadow of stg2
   cp_word_t stg2_d;

   // ------------------------------------------------------------------------
   // second stage source
   // ------------------------------------------------------------------------
   always_comb
   begin
      if (IS_MASTER)
      begin
         stg2_d = master_in;   // head of chain restarts from master
      end
      else if (mode.double_en)
      begin
         stg2_d = shd1_q;      // extra hop delay
      end
      else
      begin
         stg2_d = stg1_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || clr)
      begin
         stg1_q <= '0;
         stg2_q <= '0;
         shd1_q <= '0;
         shd2_q <= '0;
      end
      else if (data_enable)
      begin
         stg1_q <= dist_in;
         stg2_q <= stg2_d;
         shd1_q <= stg1_q;     // shadows trail by one enable
         shd2_q <= stg2_q;
      end
   end

   // ------------------------------------------------------------------------
   // output select
   // ------------------------------------------------------------------------
   always_comb
   begin
      if (mode.bypass)
      begin
         dist_tap = dist_in;                            // straight through
         dist_out = IS_MASTER ? master_in : dist_in;
      end
      else if (mode.double_en)
      begin
         dist_tap = shd1_q;
         dist_out = shd2_q;
      end
      else
      begin
         dist_tap = stg1_q;
         dist_out = stg2_q;
      end
   end

   // pipeline frozen between enables
   a_frozen_without_enable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (!data_enable && !clr) |=> $stable({stg1_q, stg2_q, shd1_q, shd2_q})
   );

endmodule

// ==== rtl/cp_dist_chain.sv ====
/*
 * control-plane distribution chain
 * NUM_CH cells in a daisy chain, channel 0 is the master
 */
`timescale 1ns/100ps

module cp_dist_chain
   import cp_dist_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     clr,
   input  logic     data_enable,
   input  cp_word_t master_word,
   input  cp_mode_t mode,
   output cp_taps_t taps
);

   // link[i] is what cell i sees on dist_in
   cp_word_t link [NUM_CH];

   assign link[0] = master_word;   // head takes master on both inputs

   for (genvar i = 0; i < NUM_CH; i++)
   begin : g_cell
      if (i < NUM_CH - 1)
      begin : g_mid
         cp_dist_cell #(
            .IS_MASTER (i == 0)
         ) u_cell (
            .clk         (clk),
            .rst_n       (rst_n),
            .clr         (clr),
            .data_enable (data_enable),
            .master_in   (master_word),
            .dist_in     (link[i]),
            .mode        (mode),
            .dist_out    (link[i+1]),   // on to next channel
            .dist_tap    (taps[i])
         );
      end
      else
      begin : g_last
         cp_dist_cell #(
            .IS_MASTER (i == 0)
         ) u_cell (
            .clk         (clk),
            .rst_n       (rst_n),
            .clr         (clr),
            .data_enable (data_enable),
            .master_in   (master_word),
            .dist_in     (link[i]),
            .mode        (mode),
            .dist_out    (),            // end of chain
            .dist_tap    (taps[i])
         );
      end
   end

endmodule

// ==== rtl/cp_dist_ctrl_fsm.sv ====
/*
 * distribution control FSM
 * sequences apply, chain clear, load, settle and the done pulse
 */
`timescale 1ns/100ps

module cp_dist_ctrl_fsm
   import cp_dist_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic apply,          // ignored outside idle
   input  logic mode_changed,   // sampled with apply
   input  logic settled,
   output logic clr,
   output logic settle_start,
   output logic busy,
   output logic done
);

   cp_state_e state_q;
   cp_state_e state_d;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= ST_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // ------------------------------------------------------------------------
   // next state
   // ------------------------------------------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
         begin
            if (apply)
            begin
               // flush stale data only when the path shape changes
               state_d = mode_changed ? ST_CLEAR : ST_LOAD;
            end
         end
         ST_CLEAR:
         begin
            state_d = ST_LOAD;
         end
         ST_LOAD:
         begin
            state_d = ST_SETTLE;
         end
         ST_SETTLE:
         begin
            if (settled)
            begin
               state_d = ST_DONE;   // otherwise sit here
            end
         end
         ST_DONE:
         begin
            state_d = ST_IDLE;
         end
         default:
         begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // outputs straight from state
   assign clr          = (state_q == ST_CLEAR);
   assign settle_start = (state_q == ST_LOAD);
   assign busy         = (state_q != ST_IDLE);
   assign done         = (state_q == ST_DONE);

   a_done_one_cycle : assert property (
      @(posedge clk) disable iff (!rst_n)
      done |=> !done
   );

   // timer restarts its count on load so done never rides a stale settle
   a_settle_restart : assert property (
      @(posedge clk) disable iff (!rst_n)
      settle_start |=> !settled
   );

endmodule

// ==== rtl/cp_dist_pkg.sv ====
/*
 * control-plane distribution package
 * channel count, word and mode types, FSM states and settle bounds
 */
package cp_dist_pkg;

   // ------------------------------------------------------------------------
   // chain geometry
   // ------------------------------------------------------------------------
   localparam int unsigned NUM_CH = 4;   // channels on the daisy chain
   localparam int unsigned CW     = 8;   // control word width

   typedef logic [CW-1:0] cp_word_t;

   // slice i belongs to channel i
   typedef cp_word_t [NUM_CH-1:0] cp_taps_t;

   typedef struct packed {
      logic bypass;      // skip pipeline regs, taps go combinational
      logic double_en;   // shadow stage per hop, half rate enable
   } cp_mode_t;

   // ------------------------------------------------------------------------
   // control sequencer
   // ------------------------------------------------------------------------
   typedef enum logic [2:0] {
      ST_IDLE   = 3'd0,   // waiting for apply
      ST_CLEAR  = 3'd1,   // mode change, flush chain
      ST_LOAD   = 3'd2,   // restart settle count
      ST_SETTLE = 3'd3,   // wait for all taps
      ST_DONE   = 3'd4    // one cycle done pulse
   } cp_state_e;

   // ------------------------------------------------------------------------
   // settle bounds, in data_enable pulses
   // ------------------------------------------------------------------------
   // two stages per hop at full rate
   localparam int unsigned SETTLE_NORM = 2 * NUM_CH + 1;
   // primary plus shadow per stage
   localparam int unsigned SETTLE_DBL  = 4 * NUM_CH + 2;
   // nothing registered on the path
   localparam int unsigned SETTLE_BYP  = 1;

   localparam int unsigned CNT_W = 5;   // holds SETTLE_DBL

endpackage

// ==== rtl/cp_dist_timer.sv ====
/*
 * distribution rate timer
 * full or half rate data enable, paused by hold, and settle counter
 */
`timescale 1ns/100ps

module cp_dist_timer
   import cp_dist_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     clr,
   input  logic     hold,
   input  cp_mode_t mode,
   input  logic     settle_start,
   output logic     data_enable,
   output logic     settled
);

   logic             run_q;       // armed by first clear or load
   logic             phase_q;     // 0 = enable slot in double mode
   logic             half_rate;
   logic [CNT_W-1:0] cnt_q;       // enables since settle_start
   logic [CNT_W-1:0] target;

   assign half_rate = mode.double_en & ~mode.bypass;   // bypass wins, as in the cell

   // ------------------------------------------------------------------------
   // rate enable
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         run_q <= 1'b0;
      end
      else if (clr || settle_start)
      begin
         run_q <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || clr)
      begin
         phase_q <= 1'b0;          // first slot right after clear
      end
      else if (run_q && !hold)
      begin
         phase_q <= ~phase_q;      // phase pauses with hold
      end
   end

   assign data_enable = run_q & ~hold & (~half_rate | ~phase_q);

   // ------------------------------------------------------------------------
   // settle count
   // ------------------------------------------------------------------------
   always_comb
   begin
      if (mode.bypass)
      begin
         target = CNT_W'(SETTLE_BYP);
      end
      else if (mode.double_en)
      begin
         target = CNT_W'(SETTLE_DBL);
      end
      else
      begin
         target = CNT_W'(SETTLE_NORM);
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || clr || settle_start)
      begin
         cnt_q <= '0;
      end
      else if (data_enable && (cnt_q < target))
      begin
         cnt_q <= cnt_q + 1'b1;   // saturates at target
      end
   end

   assign settled = (cnt_q == target);

   a_no_enable_in_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      hold |-> !data_enable
   );

   // double mode never fires back to back
   a_half_rate_spacing : assert property (
      @(posedge clk) disable iff (!rst_n || clr)
      (data_enable && half_rate) |=> !data_enable
   );

endmodule

// ==== rtl/cp_dist_top.sv ====
/*
 * control-plane distribution top
 * word and mode registers, control FSM, rate timer and cell chain
 */
`timescale 1ns/100ps

module cp_dist_top
   import cp_dist_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     apply,     // one cycle strobe
   input  cp_word_t word_in,
   input  cp_mode_t mode_in,
   input  logic     hold,      // freeze distribution
   output cp_taps_t taps,
   output logic     busy,
   output logic     done
);

   cp_word_t word_q;         // master word
   cp_mode_t mode_q;         // active mode
   logic     take;           // accepted apply
   logic     mode_changed;
   logic     clr;
   logic     settle_start;
   logic     data_enable;
   logic     settled;

   assign take         = apply & ~busy;
   assign mode_changed = (mode_in != mode_q);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mode_q <= '0;       // normal mode
      end
      else if (take)
      begin
         mode_q <= mode_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         word_q <= word_in;
      end
   end

   cp_dist_ctrl_fsm u_ctrl_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .apply        (apply),
      .mode_changed (mode_changed),
      .settled      (settled),
      .clr          (clr),
      .settle_start (settle_start),
      .busy         (busy),
      .done         (done)
   );

   cp_dist_timer u_timer (
      .clk          (clk),
      .rst_n        (rst_n),
      .clr          (clr),
      .hold         (hold),
      .mode         (mode_q),
      .settle_start (settle_start),
      .data_enable  (data_enable),
      .settled      (settled)
   );

   cp_dist_chain u_chain (
      .clk          (clk),
      .rst_n        (rst_n),
      .clr          (clr),
      .data_enable  (data_enable),
      .master_word  (word_q),
      .mode         (mode_q),
      .taps         (taps)
   );

endmodule

// ==== test/tb_cp_dist_top.sv ====
/*
 * testbench for the control-plane distribution top
 * directed tests of reset, normal, double, bypass, hold and busy apply
 */
`timescale 1ns/100ps

module tb_cp_dist_top
   import cp_dist_pkg::*;
();

   logic        clk;
   logic        rst_n;
   logic        apply;
   cp_word_t    word_in;
   cp_mode_t    mode_in;
   logic        hold;
   cp_taps_t    taps;
   logic        busy;
   logic        done;
   logic [31:0] rng_state;   // xorshift state

   cp_dist_top u_cp_dist_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .apply   (apply),
      .word_in (word_in),
      .mode_in (mode_in),
      .hold    (hold),
      .taps    (taps),
      .busy    (busy),
      .done    (done)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;   // 8 ns period
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic cp_mode_t make_mode(input logic byp, input logic dbl);
      cp_mode_t m;
      m.bypass    = byp;
      m.double_en = dbl;
      return m;
   endfunction

   task automatic next_word(output cp_word_t w);
      rng_state = xorshift32(rng_state);
      w = rng_state[CW-1:0];
   endtask

   // drive and sample point 1 ns past the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic check_taps(input cp_word_t exp);
      for (int i = 0; i < NUM_CH; i++)
      begin
         check_value($sformatf("taps[%0d]", i), taps[i], exp);
      end
   endtask

   // one cycle apply strobe then busy follows
   task automatic apply_word(input cp_word_t w, input cp_mode_t m);
      apply   = 1'b1;
      word_in = w;
      mode_in = m;
      next_cycle();
      apply = 1'b0;
      check_value("busy", busy, 1'b1);
   endtask

   task automatic wait_done(input bit busy_chk);
      int n;
      n = 0;
      while (!done)
      begin
         if (busy_chk)
            check_value("busy", busy, 1'b1);   // busy until done
         if (n == 200)
         begin
            $display("done never arrived within 200 cycles");
            $display("Simulation FAILED");
            $fatal(1, "timeout waiting for done");
         end
         else
         begin
            next_cycle();
            n++;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic test_reset_state();
      check_taps('0);
      check_value("busy", busy, 1'b0);
      check_value("done", done, 1'b0);
   endtask

   task automatic test_normal_mode();
      cp_word_t w;
      repeat (3)
      begin
         next_word(w);
         apply_word(w, make_mode(1'b0, 1'b0));
         wait_done(1'b1);
         check_taps(w);
         next_cycle();
         check_value("busy", busy, 1'b0);   // back in idle
         check_value("done", done, 1'b0);
      end
   endtask

   task automatic test_double_mode();
      cp_word_t w1;
      cp_word_t w2;
      next_word(w1);
      apply_word(w1, make_mode(1'b0, 1'b1));   // mode change
      next_cycle();
      check_taps('0);                          // chain flushed
      wait_done(1'b1);
      check_taps(w1);
      next_cycle();
      next_word(w2);
      if (w2 == w1)
         w2 = ~w1;
      apply_word(w2, make_mode(1'b0, 1'b1));   // same mode
      next_cycle();
      // no flush so far tap still holds the old word
      check_value("taps[3]", taps[NUM_CH-1], w1);
      wait_done(1'b1);
      check_taps(w2);
      next_cycle();
   endtask

   task automatic test_bypass_mode();
      cp_word_t w1;
      cp_word_t w2;
      next_word(w1);
      apply_word(w1, make_mode(1'b1, 1'b0));
      wait_done(1'b1);
      check_taps(w1);
      next_cycle();
      next_word(w2);
      if (w2 == w1)
         w2 = ~w1;
      apply_word(w2, make_mode(1'b1, 1'b0));
      check_taps(w2);                      // straight from word register
      check_value("done", done, 1'b0);
      wait_done(1'b1);
      check_taps(w2);
      next_cycle();
   endtask

   task automatic test_hold();
      cp_word_t w;
      cp_taps_t frozen;
      next_word(w);
      apply_word(w, make_mode(1'b0, 1'b0));
      repeat (4)
      begin
         next_cycle();
         check_value("done", done, 1'b0);
      end
      hold   = 1'b1;
      frozen = taps;
      repeat (12)
      begin
         next_cycle();
         check_value("taps", taps, frozen);
         check_value("done", done, 1'b0);
      end
      hold = 1'b0;
      wait_done(1'b1);
      check_taps(w);
      next_cycle();
   endtask

   task automatic test_apply_while_busy();
      cp_word_t wa;
      cp_word_t wb;
      next_word(wa);
      wb = wa ^ 8'h5a;                     // always differs
      apply_word(wa, make_mode(1'b0, 1'b0));
      repeat (3)
      begin
         next_cycle();
      end
      apply_word(wb, make_mode(1'b0, 1'b1));   // must be dropped
      wait_done(1'b1);
      check_taps(wa);
      next_cycle();
      check_value("busy", busy, 1'b0);
   endtask

   // ------------------------------------------------------------------------
   // sequence
   // ------------------------------------------------------------------------
   initial
   begin
      rst_n     = 1'b0;
      apply     = 1'b0;
      word_in   = '0;
      mode_in   = '0;
      hold      = 1'b0;
      rng_state = 32'he191cbd8;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      next_cycle();
      test_reset_state();
      test_normal_mode();
      test_double_mode();
      test_bypass_mode();
      test_hold();
      test_apply_while_busy();
      $display("Simulation PASSED");
      $finish;
   end

endmodule
